//--- all.f
hdl/kcpu_pkg.sv
hdl/kcpu_alu.sv
hdl/kcpu_idx.sv
hdl/kcpu_regs.sv
hdl/kcpu_memctrl.sv
hdl/kcpu_ctrl.sv
hdl/kcpu.sv
verification/kcpu_assert.sv
verification/kcpu_tb.sv

//--- hdl/kcpu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit core top level on a byte-wide bus.
// reset_pc sets the first fetch address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu #(
    parameter logic [15:0] reset_pc = 16'h0000
) (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         cen,
    input  wire         halt,
    input  wire         dtack,
    input  wire  [ 7:0] din,
    output logic [ 7:0] dout,
    output logic [15:0] addr,
    output logic        we
);

    logic [15:0] mdata, ea, x, pc;
    logic [ 7:0] op, a, dp, cc, cc_out, rslt, opnd;
    logic        fetch, opd, ld_ea, up_a, up_x, up_cc, up_pc, jmp, wrq;
    logic        clken;

    kcpu_pkg::mode_t     mode;
    kcpu_pkg::alu_op_t   alu_op;
    kcpu_pkg::addr_sel_t addr_sel;

    // dtack low stretches the bus cycle by dropping the enable
    always_ff @(negedge clk or negedge arst_n) begin
        if (!arst_n)
            clken <= 1'b0;
        else
            clken <= cen & dtack;
    end

    kcpu_ctrl u_ctrl (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .clken    ( clken    ),
        .halt     ( halt     ),
        .op       ( op       ),
        .cc       ( cc       ),
        .fetch    ( fetch    ),
        .opd      ( opd      ),
        .mode     ( mode     ),
        .alu_op   ( alu_op   ),
        .addr_sel ( addr_sel ),
        .ld_ea    ( ld_ea    ),
        .up_a     ( up_a     ),
        .up_x     ( up_x     ),
        .up_cc    ( up_cc    ),
        .up_pc    ( up_pc    ),
        .jmp      ( jmp      ),
        .wrq      ( wrq      )
    );

    kcpu_regs #(.reset_pc(reset_pc)) u_regs (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .clken    ( clken    ),
        .up_a     ( up_a     ),
        .up_x     ( up_x     ),
        .up_cc    ( up_cc    ),
        .up_pc    ( up_pc    ),
        .jmp      ( jmp      ),
        .opd      ( opd      ),
        .fetch    ( fetch    ),
        .mdata    ( mdata    ),
        .rslt     ( rslt     ),
        .cc_out   ( cc_out   ),
        .ea       ( ea       ),
        .a        ( a        ),
        .x        ( x        ),
        .dp       ( dp       ),
        .pc       ( pc       ),
        .cc       ( cc       ),
        .opnd     ( opnd     )
    );

    kcpu_alu u_alu (
        .alu_op   ( alu_op   ),
        .a        ( a        ),
        .opnd     ( opnd     ),
        .cc_in    ( cc       ),
        .rslt     ( rslt     ),
        .cc_out   ( cc_out   )
    );

    kcpu_idx u_idx (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .clken    ( clken    ),
        .ld_ea    ( ld_ea    ),
        .mode     ( mode     ),
        .x        ( x        ),
        .dp       ( dp       ),
        .mdata    ( mdata    ),
        .ea       ( ea       )
    );

    kcpu_memctrl u_memctrl (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .clken    ( clken    ),
        .fetch    ( fetch    ),
        .opd      ( opd      ),
        .addr_sel ( addr_sel ),
        .wrq      ( wrq      ),
        .pc       ( pc       ),
        .ea       ( ea       ),
        .a        ( a        ),
        .din      ( din      ),
        .op       ( op       ),
        .mdata    ( mdata    ),
        .addr     ( addr     ),
        .dout     ( dout     ),
        .we       ( we       )
    );

endmodule

`default_nettype wire

//--- hdl/kcpu_alu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational 8-bit ALU with N Z V C generation.
// Other CC bits pass through unchanged
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_alu (
    input  wire kcpu_pkg::alu_op_t alu_op,
    input  wire  [7:0]        a,
    input  wire  [7:0]        opnd,
    input  wire  [7:0]        cc_in,
    output logic [7:0]        rslt,
    output logic [7:0]        cc_out
);

    logic [8:0] sum;

    always_comb begin
        cc_out = cc_in;
        sum    = 9'd0;
        case (alu_op)
            kcpu_pkg::alu_add: begin
                sum  = {1'b0, a} + {1'b0, opnd};
                rslt = sum[7:0];
                cc_out[kcpu_pkg::flag_c] = sum[8];
                // same input signs but result sign differs
                cc_out[kcpu_pkg::flag_v] = (a[7] == opnd[7]) && (sum[7] != a[7]);
            end
            kcpu_pkg::alu_sub: begin
                sum  = {1'b0, a} - {1'b0, opnd};
                rslt = sum[7:0];
                // bit 8 set means borrow
                cc_out[kcpu_pkg::flag_c] = sum[8];
                cc_out[kcpu_pkg::flag_v] = (a[7] != opnd[7]) && (sum[7] != a[7]);
            end
            kcpu_pkg::alu_and: begin
                rslt = a & opnd;
                cc_out[kcpu_pkg::flag_v] = 1'b0;
            end
            default: begin
                rslt = opnd;
                cc_out[kcpu_pkg::flag_v] = 1'b0;
            end
        endcase
        cc_out[kcpu_pkg::flag_n] = rslt[7];
        cc_out[kcpu_pkg::flag_z] = (rslt == 8'h00);
    end

endmodule

`default_nettype wire

//--- hdl/kcpu_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction sequencer. Decodes the opcode and drives
// register updates, address loads and bus strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_ctrl (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  clken,
    input  wire                  halt,
    input  wire  [7:0]           op,
    input  wire  [7:0]           cc,
    output logic                 fetch,
    output logic                 opd,
    output kcpu_pkg::mode_t      mode,
    output kcpu_pkg::alu_op_t    alu_op,
    output kcpu_pkg::addr_sel_t  addr_sel,
    output logic                 ld_ea,
    output logic                 up_a,
    output logic                 up_x,
    output logic                 up_cc,
    output logic                 up_pc,
    output logic                 jmp,
    output logic                 wrq
);

    typedef enum logic [2:0] {
        st_fetch, st_opdh, st_opdl, st_addr, st_exec, st_write
    } state_t;

    state_t st, st_nx;
    logic   legal, wide;

    // mode sits in opcode bits 5:4 for the 8x..Bx rows
    assign mode = kcpu_pkg::mode_t'(op[5:4]);

    always_comb begin
        legal  = 1'b1;
        wide   = 1'b0;
        alu_op = kcpu_pkg::alu_pass;
        case (op)
            kcpu_pkg::op_adda_imm: alu_op = kcpu_pkg::alu_add;
            kcpu_pkg::op_suba_imm: alu_op = kcpu_pkg::alu_sub;
            kcpu_pkg::op_anda_imm: alu_op = kcpu_pkg::alu_and;
            kcpu_pkg::op_ldx_imm, kcpu_pkg::op_lda_ext,
            kcpu_pkg::op_sta_ext, kcpu_pkg::op_jmp_ext: wide = 1'b1;
            kcpu_pkg::op_lda_imm, kcpu_pkg::op_lda_dir, kcpu_pkg::op_sta_dir,
            kcpu_pkg::op_lda_idx, kcpu_pkg::op_sta_idx, kcpu_pkg::op_leax_idx,
            kcpu_pkg::op_bne: legal = 1'b1;
            // NOP has no operand, same path as an unknown opcode
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        st_nx    = st;
        fetch    = 1'b0;
        opd      = 1'b0;
        ld_ea    = 1'b0;
        up_a     = 1'b0;
        up_x     = 1'b0;
        up_cc    = 1'b0;
        up_pc    = 1'b0;
        jmp      = 1'b0;
        wrq      = 1'b0;
        addr_sel = kcpu_pkg::addr_pc;
        case (st)
            st_fetch: begin
                // halt only bites between instructions
                if (!halt) begin
                    fetch = 1'b1;
                    if (!legal)
                        st_nx = st_fetch;
                    else if (wide)
                        st_nx = st_opdh;
                    else
                        st_nx = st_opdl;
                end
            end
            st_opdh: begin
                opd   = 1'b1;
                st_nx = st_opdl;
            end
            st_opdl: begin
                opd   = 1'b1;
                st_nx = st_fetch;
                case (op)
                    kcpu_pkg::op_lda_imm, kcpu_pkg::op_adda_imm,
                    kcpu_pkg::op_suba_imm, kcpu_pkg::op_anda_imm: begin
                        up_a  = 1'b1;
                        up_cc = 1'b1;
                    end
                    kcpu_pkg::op_ldx_imm: up_x = 1'b1;
                    kcpu_pkg::op_jmp_ext: begin
                        up_pc = 1'b1;
                        jmp   = 1'b1;
                    end
                    // branch when Z is clear
                    kcpu_pkg::op_bne: up_pc = ~cc[kcpu_pkg::flag_z];
                    kcpu_pkg::op_lda_dir, kcpu_pkg::op_lda_ext: begin
                        ld_ea = 1'b1;
                        st_nx = st_exec;
                    end
                    kcpu_pkg::op_sta_dir, kcpu_pkg::op_sta_ext: begin
                        ld_ea = 1'b1;
                        st_nx = st_write;
                    end
                    kcpu_pkg::op_lda_idx, kcpu_pkg::op_sta_idx,
                    kcpu_pkg::op_leax_idx: st_nx = st_addr;
                    default: st_nx = st_fetch;
                endcase
            end
            st_addr: begin
                ld_ea = 1'b1;
                st_nx = (op == kcpu_pkg::op_sta_idx) ? st_write : st_exec;
            end
            st_exec: begin
                addr_sel = kcpu_pkg::addr_ea;
                st_nx    = st_fetch;
                if (op == kcpu_pkg::op_leax_idx) begin
                    up_x = 1'b1;
                end else begin
                    up_a  = 1'b1;
                    up_cc = 1'b1;
                end
            end
            st_write: begin
                addr_sel = kcpu_pkg::addr_ea;
                wrq      = 1'b1;
                st_nx    = st_fetch;
            end
            default: st_nx = st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            st <= st_fetch;
        else if (clken)
            st <= st_nx;
    end

endmodule

`default_nettype wire

//--- hdl/kcpu_idx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Effective address register for direct,
// indexed and extended operand modes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_idx (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             clken,
    input  wire             ld_ea,
    input  wire kcpu_pkg::mode_t mode,
    input  wire  [15:0]     x,
    input  wire  [ 7:0]     dp,
    input  wire  [15:0]     mdata,
    output logic [15:0]     ea
);

    logic [15:0] ofs;

    // in the address cycle the offset byte has moved to the high half
    assign ofs = {{8{mdata[15]}}, mdata[15:8]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ea <= 16'h0000;
        end else if (clken && ld_ea) begin
            case (mode)
                kcpu_pkg::mode_dir: ea <= {dp, mdata[7:0]};
                kcpu_pkg::mode_idx: ea <= x + ofs;
                // extended takes the full 16-bit operand
                default:            ea <= mdata;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/kcpu_memctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus side of the core. Picks the address, latches
// opcodes, assembles operands and drives writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_memctrl (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  clken,
    input  wire                  fetch,
    input  wire                  opd,
    input  wire kcpu_pkg::addr_sel_t addr_sel,
    input  wire                  wrq,
    input  wire  [15:0]          pc,
    input  wire  [15:0]          ea,
    input  wire  [ 7:0]          a,
    input  wire  [ 7:0]          din,
    output logic [ 7:0]          op,
    output logic [15:0]          mdata,
    output logic [15:0]          addr,
    output logic [ 7:0]          dout,
    output logic                 we
);

    logic [7:0] op_q;
    logic [7:0] mbuf;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            op_q <= kcpu_pkg::op_nop;
        else if (clken && fetch)
            op_q <= din;
    end

    // previous operand byte so the high byte comes first
    always_ff @(posedge clk) begin
        if (clken && opd)
            mbuf <= din;
    end

    // sequencer sees the new opcode already in the fetch cycle
    assign op    = fetch ? din : op_q;
    assign mdata = {mbuf, din};

    always_comb begin
        case (addr_sel)
            kcpu_pkg::addr_ea: addr = ea;
            default:           addr = pc;
        endcase
    end

    // single write cycle with data straight from A
    assign we   = wrq;
    assign dout = a;

endmodule

`default_nettype wire

//--- hdl/kcpu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Encodings shared by the kcpu core blocks: opcodes,
// addressing modes, ALU operations, bus sources and CC bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package kcpu_pkg;

    // moded opcodes: high nibble 8/9/A/B = imm/dir/idx/ext
    localparam logic [7:0] op_nop      = 8'h12;
    localparam logic [7:0] op_bne      = 8'h26;
    localparam logic [7:0] op_suba_imm = 8'h80;
    localparam logic [7:0] op_anda_imm = 8'h84;
    localparam logic [7:0] op_lda_imm  = 8'h86;
    localparam logic [7:0] op_adda_imm = 8'h8B;
    localparam logic [7:0] op_ldx_imm  = 8'h8E;
    localparam logic [7:0] op_lda_dir  = 8'h96;
    localparam logic [7:0] op_sta_dir  = 8'h97;
    localparam logic [7:0] op_leax_idx = 8'hA2;
    localparam logic [7:0] op_lda_idx  = 8'hA6;
    localparam logic [7:0] op_sta_idx  = 8'hA7;
    localparam logic [7:0] op_lda_ext  = 8'hB6;
    localparam logic [7:0] op_sta_ext  = 8'hB7;
    localparam logic [7:0] op_jmp_ext  = 8'hBC;

    // same order as opcode bits 5:4
    typedef enum logic [1:0] {
        mode_imm = 2'd0,
        mode_dir = 2'd1,
        mode_idx = 2'd2,
        mode_ext = 2'd3
    } mode_t;

    typedef enum logic [1:0] {
        alu_pass = 2'd0,
        alu_add  = 2'd1,
        alu_sub  = 2'd2,
        alu_and  = 2'd3
    } alu_op_t;

    typedef enum logic [1:0] {
        addr_pc = 2'd0,
        addr_ea = 2'd1
    } addr_sel_t;

    // CC bit positions, 6809 layout
    localparam int flag_c = 0;
    localparam int flag_v = 1;
    localparam int flag_z = 2;
    localparam int flag_n = 3;

endpackage

`default_nettype wire

//--- hdl/kcpu_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Programmer registers A, X, PC and CC plus the
// fixed direct page. Updated by the sequencer strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_regs #(
    parameter logic [15:0] reset_pc = 16'h0000
) (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         clken,
    input  wire         up_a,
    input  wire         up_x,
    input  wire         up_cc,
    input  wire         up_pc,
    input  wire         jmp,
    input  wire         opd,
    input  wire         fetch,
    input  wire  [15:0] mdata,
    input  wire  [ 7:0] rslt,
    input  wire  [ 7:0] cc_out,
    input  wire  [15:0] ea,
    output logic [ 7:0] a,
    output logic [15:0] x,
    output logic [ 7:0] dp,
    output logic [15:0] pc,
    output logic [ 7:0] cc,
    output logic [ 7:0] opnd
);

    logic [15:0] rel;

    // no instruction in this subset loads DP
    assign dp = 8'h00;

    // ALU operand is always the live memory byte
    assign opnd = mdata[7:0];

    // branch target counts from the byte after the offset
    assign rel = pc + 16'd1 + {{8{mdata[7]}}, mdata[7:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a  <= 8'h00;
            x  <= 16'h0000;
            cc <= 8'h00;
            pc <= reset_pc;
        end else if (clken) begin
            if (up_a)
                a <= rslt;
            if (up_cc)
                cc <= cc_out;
            // LDX loads during an operand cycle, LEAX afterwards
            if (up_x)
                x <= opd ? mdata : ea;
            if (up_pc && jmp)
                pc <= mdata;
            else if (up_pc)
                pc <= rel;
            else if (fetch || opd)
                pc <= pc + 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- verification/kcpu_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus and enable properties of the kcpu core,
// bound into every kcpu instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_assert (
    input wire        clk,
    input wire        arst_n,
    input wire        clken,
    input wire        we,
    input wire [15:0] addr
);

    int fails = 0;

    // a write strobe lasts one enabled cycle only
    we_single: assert property (@(posedge clk) disable iff (!arst_n)
        (clken && we) |=> !we)
    else begin
        fails++;
        $error("write strobe high in two consecutive enabled cycles");
    end

    // stalled cycles keep the bus frozen
    bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !clken |=> ($stable(addr) && $stable(we)))
    else begin
        fails++;
        $error("address or write strobe moved while the enable was low");
    end

    bus_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(addr) && !$isunknown(we))
    else begin
        fails++;
        $error("unknown value on the address bus or write strobe");
    end

endmodule

bind kcpu kcpu_assert u_assert (
    .clk    ( clk    ),
    .arst_n ( arst_n ),
    .clken  ( clken  ),
    .we     ( we     ),
    .addr   ( addr   )
);

`default_nettype wire

//--- verification/kcpu_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the kcpu core: memory model, small programs,
// an instruction-level reference model and a write comparer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kcpu_tb;

    localparam logic [15:0] start_pc = 16'h0100;
    // six tests of a few hundred cycles each, stalls at most triple that
    localparam int max_cycles = 20000;

    logic        clk = 1'b0;
    logic        arst_n, cen, dtack, halt, we, rand_en;
    logic [ 7:0] din, dout, exp_a;
    logic [15:0] addr, wp, loop_addr, held_addr;
    logic [ 7:0] mem  [0:65535];
    logic [ 7:0] img  [0:65535];
    logic [ 7:0] rmem [0:65535];
    // expected writes, address in 23:8 and data in 7:0
    logic [23:0] exp_q [$];
    logic [23:0] exp_w;
    int          errors, err_base, checks, tests, wr_seen, held_wr, loop_hits;
    int          cycle_cnt = 0;
    int unsigned seed_val;

    always #20 clk = ~clk;

    kcpu #(.reset_pc(start_pc)) i_dut (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .halt   ( halt   ),
        .dtack  ( dtack  ),
        .din    ( din    ),
        .dout   ( dout   ),
        .addr   ( addr   ),
        .we     ( we     )
    );

    assign din = mem[addr];

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (i_dut.clken && we)
            mem[addr] <= dout;
        if (i_dut.clken && i_dut.fetch && addr == loop_addr)
            loop_hits++;
        if (rand_en) begin
            cen   <= ($urandom % 4) != 0;
            dtack <= ($urandom % 3) != 0;
        end else begin
            cen   <= 1'b1;
            dtack <= 1'b1;
        end
    end

    // every bus write is matched against the reference list
    always @(posedge clk) begin
        if (i_dut.clken && we) begin
            wr_seen++;
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("unexpected write of %h to %h at %0t", dout, addr, $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_w = exp_q.pop_front();
                assert (addr === exp_w[23:8] && dout === exp_w[7:0]) else begin
                    $display("Fail at %0t: wrote %h to %h, expected %h to %h",
                             $time, dout, addr, exp_w[7:0], exp_w[23:8]);
                    errors++;
                end
            end
        end
    end

    // instruction-level model of the program in img, returns final A
    function automatic logic [7:0] ref_run();
        logic [15:0] pc, x, ea, sx;
        logic [ 7:0] a, op, b;
        logic        z, done;
        int          i, steps;
        for (i = 0; i < 65536; i++)
            rmem[i] = img[i];
        exp_q.delete();
        pc    = start_pc;
        x     = 16'h0000;
        ea    = 16'h0000;
        a     = 8'h00;
        z     = 1'b0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            steps++;
            op = rmem[pc];
            b  = rmem[pc + 16'd1];
            sx = {{8{b[7]}}, b};
            pc = pc + 16'd1;
            case (op)
                kcpu_pkg::op_lda_imm:  a = b;
                kcpu_pkg::op_adda_imm: a = a + b;
                kcpu_pkg::op_suba_imm: a = a - b;
                kcpu_pkg::op_anda_imm: a = a & b;
                kcpu_pkg::op_ldx_imm:  x = {b, rmem[pc + 16'd1]};
                kcpu_pkg::op_lda_dir, kcpu_pkg::op_sta_dir: ea = {8'h00, b};
                kcpu_pkg::op_lda_idx, kcpu_pkg::op_sta_idx,
                kcpu_pkg::op_leax_idx: ea = x + sx;
                kcpu_pkg::op_lda_ext, kcpu_pkg::op_sta_ext: ea = {b, rmem[pc + 16'd1]};
                kcpu_pkg::op_jmp_ext: begin
                    ea   = {b, rmem[pc + 16'd1]};
                    done = (ea == pc - 16'd1);
                end
                // offset counts from the byte after it, taken while Z is clear
                kcpu_pkg::op_bne: if (!z) pc = pc + sx;
                default: ;
            endcase
            if (op == kcpu_pkg::op_jmp_ext)
                pc = ea;
            else if (op inside {kcpu_pkg::op_ldx_imm, kcpu_pkg::op_lda_ext,
                                kcpu_pkg::op_sta_ext})
                pc = pc + 16'd2;
            else if (!(op inside {kcpu_pkg::op_nop}) && op[7] | (op == kcpu_pkg::op_bne))
                pc = pc + 16'd1;
            if (op inside {kcpu_pkg::op_lda_dir, kcpu_pkg::op_lda_idx, kcpu_pkg::op_lda_ext})
                a = rmem[ea];
            if (op inside {kcpu_pkg::op_sta_dir, kcpu_pkg::op_sta_idx,
                           kcpu_pkg::op_sta_ext}) begin
                rmem[ea] = a;
                exp_q.push_back({ea, a});
            end
            if (op == kcpu_pkg::op_leax_idx)
                x = ea;
            if (op inside {kcpu_pkg::op_lda_imm, kcpu_pkg::op_adda_imm, kcpu_pkg::op_suba_imm,
                           kcpu_pkg::op_anda_imm, kcpu_pkg::op_lda_dir,
                           kcpu_pkg::op_lda_idx, kcpu_pkg::op_lda_ext})
                z = (a == 8'h00);
        end
        return a;
    endfunction

    task automatic clear_img();
        int i;
        for (i = 0; i < 65536; i++)
            img[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        wp = start_pc;
    endtask

    task automatic ins(input logic [7:0] op, input int n, input logic [15:0] arg);
        img[wp] = op;
        wp      = wp + 16'd1;
        if (n == 2) begin
            img[wp] = arg[15:8];
            wp      = wp + 16'd1;
        end
        if (n >= 1) begin
            img[wp] = arg[7:0];
            wp      = wp + 16'd1;
        end
    endtask

    // self loop that marks the end of a program
    task automatic end_loop();
        loop_addr = wp;
        ins(kcpu_pkg::op_jmp_ext, 2, wp);
    endtask

    task automatic build_basic();
        clear_img();
        ins(kcpu_pkg::op_lda_imm, 1, 16'h005A);
        ins(kcpu_pkg::op_sta_dir, 1, 16'h0040);
        ins(kcpu_pkg::op_lda_imm, 1, 16'h00C3);
        ins(kcpu_pkg::op_sta_ext, 2, 16'h2000);
        ins(kcpu_pkg::op_lda_dir, 1, 16'h0040);
        ins(kcpu_pkg::op_sta_ext, 2, 16'h2001);
        ins(kcpu_pkg::op_lda_ext, 2, 16'h3010);
        ins(kcpu_pkg::op_nop, 0, 16'h0000);
        // unknown opcode, runs as NOP
        ins(8'h01, 0, 16'h0000);
        ins(kcpu_pkg::op_sta_dir, 1, 16'h0041);
        end_loop();
    endtask

    task automatic build_alu();
        logic [15:0] top;
        clear_img();
        ins(kcpu_pkg::op_lda_imm,  1, 16'h007F);
        ins(kcpu_pkg::op_adda_imm, 1, 16'h0001);
        ins(kcpu_pkg::op_sta_ext,  2, 16'h2010);
        ins(kcpu_pkg::op_adda_imm, 1, 16'h0090);
        ins(kcpu_pkg::op_sta_ext,  2, 16'h2011);
        ins(kcpu_pkg::op_suba_imm, 1, 16'h0020);
        ins(kcpu_pkg::op_sta_dir,  1, 16'h0012);
        ins(kcpu_pkg::op_anda_imm, 1, 16'h003C);
        ins(kcpu_pkg::op_sta_dir,  1, 16'h0013);
        ins(kcpu_pkg::op_lda_imm,  1, 16'h0005);
        top = wp;
        ins(kcpu_pkg::op_suba_imm, 1, 16'h0001);
        ins(kcpu_pkg::op_sta_ext,  2, 16'h2020);
        ins(kcpu_pkg::op_bne,      1, top - (wp + 16'd2));
        end_loop();
    endtask

    task automatic build_index();
        clear_img();
        ins(kcpu_pkg::op_ldx_imm,  2, 16'h3000);
        ins(kcpu_pkg::op_lda_imm,  1, 16'h0011);
        ins(kcpu_pkg::op_sta_idx,  1, 16'h0005);
        ins(kcpu_pkg::op_leax_idx, 1, 16'hFFF8);
        ins(kcpu_pkg::op_lda_imm,  1, 16'h0022);
        ins(kcpu_pkg::op_sta_idx,  1, 16'hFFFD);
        ins(kcpu_pkg::op_lda_idx,  1, 16'h000D);
        ins(kcpu_pkg::op_sta_idx,  1, 16'h007F);
        ins(kcpu_pkg::op_leax_idx, 1, 16'h0080);
        ins(kcpu_pkg::op_sta_idx,  1, 16'h0000);
        end_loop();
    endtask

    // memory and reference are reloaded while the core is held in reset
    task automatic apply_reset();
        int i;
        @(posedge clk);
        arst_n <= 1'b0;
        @(posedge clk);
        checks++;
        assert (we === 1'b0) else begin
            $display("write strobe still high while reset is asserted");
            errors++;
        end
        for (i = 0; i < 65536; i++)
            mem[i] = img[i];
        exp_a     = ref_run();
        wr_seen   = 0;
        loop_hits = 0;
        repeat (7) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        checks++;
        assert (addr === start_pc) else begin
            $display("Fail at %0t: first address %h, expected %h", $time, addr, start_pc);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        while (loop_hits < 8)
            @(posedge clk);
        checks += 2;
        assert (exp_q.size() == 0) else begin
            $display("test %0d ended with %0d expected writes missing", num, exp_q.size());
            errors++;
        end
        assert (i_dut.a === exp_a) else begin
            $display("Fail at %0t: final A %h, expected %h", $time, i_dut.a, exp_a);
            errors++;
        end
        tests++;
        $display("test %0d %s: %s", num, name, (errors == err_base) ? "ok" : "errors");
    endtask

    initial begin : watchdog
        while (cycle_cnt < max_cycles)
            @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", max_cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        seed_val = $urandom(31);
        arst_n   <= 1'b0;
        cen      <= 1'b1;
        dtack    <= 1'b1;
        halt     <= 1'b0;
        rand_en   = 1'b0;
        loop_addr = 16'hFFFF;
        errors    = 0;
        checks    = 0;
        tests     = 0;

        build_basic();
        err_base = errors;
        apply_reset();
        finish_test(1, "load and store");

        build_alu();
        err_base = errors;
        apply_reset();
        finish_test(2, "alu and branch");

        build_index();
        err_base = errors;
        apply_reset();
        finish_test(3, "indexed");

        build_basic();
        err_base = errors;
        rand_en  = 1'b1;
        apply_reset();
        finish_test(4, "stalled bus");
        rand_en  = 1'b0;

        build_alu();
        err_base = errors;
        apply_reset();
        while (wr_seen < 2)
            @(posedge clk);
        halt <= 1'b1;
        // longest instruction drains before the hold
        repeat (8) @(posedge clk);
        held_addr = addr;
        held_wr   = wr_seen;
        repeat (30) @(posedge clk);
        checks++;
        assert (addr === held_addr && wr_seen == held_wr) else begin
            $display("Fail at %0t: core moved during halt, address %h from %h",
                     $time, addr, held_addr);
            errors++;
        end
        halt <= 1'b0;
        finish_test(5, "halt");

        build_index();
        err_base = errors;
        apply_reset();
        while (wr_seen < 3)
            @(posedge clk);
        apply_reset();
        finish_test(6, "reset mid-run");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, i_dut.u_assert.fails);
        if (errors == 0 && i_dut.u_assert.fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
